/* project.f */
verilog/exec_pkg.sv
verilog/operand_forward.sv
verilog/int_alu.sv
verilog/mul_stage.sv
verilog/stage_regs.sv
verilog/exec_backend.sv
dv/exec_backend_assert.sv
dv/exec_backend_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = exec_backend_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/exec_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_backend_tb import exec_pkg::*; ();

    localparam int NUM_BUNDLES  = 400;
    localparam int FAST_BUNDLES = 200;                 // Cache answers at once
    localparam int CYCLE_LIMIT  = 8 * NUM_BUNDLES + 50;

    logic clk = 1'b0;
    logic arst_n;
    logic [XLEN-1:0] ex_pc_a;
    logic [XLEN-1:0] ex_rdata_a1;
    logic [XLEN-1:0] ex_rdata_a2;
    logic [XLEN-1:0] ex_imm_a;
    logic [XLEN-1:0] ex_pc_b;
    logic [XLEN-1:0] ex_rdata_b1;
    logic [XLEN-1:0] ex_rdata_b2;
    logic [XLEN-1:0] ex_imm_b;
    logic [REG_ADDR_W-1:0] ex_raddr_a1;
    logic [REG_ADDR_W-1:0] ex_raddr_a2;
    logic [REG_ADDR_W-1:0] ex_rf_waddr_a;
    logic [REG_ADDR_W-1:0] ex_raddr_b1;
    logic [REG_ADDR_W-1:0] ex_raddr_b2;
    logic [REG_ADDR_W-1:0] ex_rf_waddr_b;
    logic [SRC_SEL_W-1:0] ex_src_sel_a;
    logic [SRC_SEL_W-1:0] ex_src_sel_b;
    logic [ALU_OP_W-1:0] ex_alu_op_a;
    logic [ALU_OP_W-1:0] ex_alu_op_b;
    logic ex_rf_we_a;
    logic ex_rf_we_b;
    logic ex_mem_we;
    logic ex_mul_signed;
    logic [WB_SEL_W-1:0] ex_wb_sel;
    logic [MEM_TYPE_W-1:0] ex_mem_type;
    logic mem_rvalid;
    logic mem_wvalid;
    logic mem_rready;
    logic mem_wready;
    logic stall;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;
    logic [MEM_TYPE_W-1:0] mem_type;
    logic rf_we_a;
    logic rf_we_b;
    logic [REG_ADDR_W-1:0] rf_waddr_a;
    logic [REG_ADDR_W-1:0] rf_waddr_b;
    logic [XLEN-1:0] rf_wdata_a;
    logic [XLEN-1:0] rf_wdata_b;

    logic [31:0] lfsr_state = 32'h27d7;
    logic [XLEN-1:0] arch [32];                        // After the newest bundle
    logic [XLEN-1:0] hist1 [32];
    logic [XLEN-1:0] hist2 [32];                       // What the register file holds at issue
    logic [XLEN-1:0] ref_mem [16];
    logic [XLEN-1:0] cache_mem [16];
    logic [REG_ADDR_W-1:0] blocked_reg;                // Load or mul dest of the last bundle
    logic pend_valid;
    logic pend_we_a;
    logic pend_we_b;
    logic fast_mode;
    logic [REG_ADDR_W-1:0] pend_addr_a;
    logic [REG_ADDR_W-1:0] pend_addr_b;
    logic [XLEN-1:0] pend_data_a;
    logic [XLEN-1:0] pend_data_b;
    int pend_seq;
    int pend_cyc;                                      // First edge after presenting
    logic exp_lane_q [$];
    logic [REG_ADDR_W-1:0] exp_addr_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    int exp_cyc_q [$];
    int exp_seq_q [$];
    logic cache_busy;
    logic cache_load;
    logic [3:0] cache_idx;
    int cache_wait;
    int cycle;
    int issued;

    always #2 clk = ~clk;

    exec_backend UUT (.*);

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] pick_reg(input logic avoid);
        logic [31:0] v;
        v = rand_bits(3);                              // r0..r7 for frequent hazards
        if (avoid && v[4:0] == blocked_reg) return '0;
        return v[4:0];
    endfunction

    // Expected value from the ISA rules
    function automatic logic [XLEN-1:0] ref_result(input int op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b, input int mul,
                                                   input logic sgn);
        logic [PROD_W-1:0] ea;
        logic [PROD_W-1:0] eb;
        logic [PROD_W-1:0] p;
        ea = sgn ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        eb = sgn ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        p  = ea * eb;
        if (mul == 1) return p[XLEN-1:0];
        if (mul == 2) return p[PROD_W-1:XLEN];
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:   return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:  return {31'b0, a < b};
            ALU_PASS2: return b;
            default:   return '0;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_wdata(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_waddr(input string name, input logic [REG_ADDR_W-1:0] exp,
                               input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_mem_type(input string name, input logic [MEM_TYPE_W-1:0] exp,
                                  input logic [MEM_TYPE_W-1:0] act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_low(input string name, input logic act);
        if (act !== 1'b0) fail_run($sformatf("ERROR %s: expected 0, actual %b", name, act));
    endtask

    task automatic compare_write(input logic lane_b, input logic [REG_ADDR_W-1:0] addr,
                                 input logic [XLEN-1:0] data);
        string name;
        int tag;
        if (exp_lane_q.size() == 0) fail_run("Register write seen with none expected");
        name = $sformatf("bundle %0d lane %s", exp_seq_q[0], lane_b ? "B" : "A");
        if (exp_lane_q.pop_front() != lane_b) fail_run({"Write out of order at ", name});
        check_waddr({name, " waddr"}, exp_addr_q.pop_front(), addr);
        check_wdata({name, " wdata"}, exp_data_q.pop_front(), data);
        tag = exp_cyc_q.pop_front();
        void'(exp_seq_q.pop_front());
        if (tag >= 0 && cycle != tag + 2) fail_run({"Write two-cycle latency missed at ", name});
    endtask

    task automatic shift_history();
        hist2 = hist1;
        hist1 = arch;
    endtask

    task automatic build_bundle(input int n);
        int op_a;
        int op_b;
        int kind;
        int mul;
        logic [31:0] v;
        logic [REG_ADDR_W-1:0] next_block;
        logic [XLEN-1:0] o1;
        logic [XLEN-1:0] o2;
        ex_pc_a = rand_bits(32);
        ex_imm_a = rand_bits(32);
        ex_pc_b = rand_bits(32);
        ex_imm_b = rand_bits(32);
        v = rand_bits(2);
        ex_src_sel_a = v[1:0];
        v = rand_bits(2);
        ex_src_sel_b = v[1:0];
        op_a = int'(rand_bits(4) % 11);
        op_b = int'(rand_bits(4) % 11);
        ex_raddr_a1 = pick_reg(1'b1);
        ex_raddr_a2 = pick_reg(1'b1);
        ex_raddr_b1 = pick_reg(1'b1);
        ex_raddr_b2 = pick_reg(1'b1);
        ex_rf_waddr_a = pick_reg(1'b0);
        ex_rf_waddr_b = pick_reg(1'b0);
        ex_rf_we_a = (rand_bits(3) != 0);
        ex_rf_we_b = 1'b1;
        // No lane A to lane B dependence inside a bundle
        if (ex_rf_we_a && ex_raddr_b1 == ex_rf_waddr_a) ex_raddr_b1 = '0;
        if (ex_rf_we_a && ex_raddr_b2 == ex_rf_waddr_a) ex_raddr_b2 = '0;
        kind = int'(rand_bits(3));
        mul = 0;
        next_block = '0;
        ex_wb_sel = 4'b0001;
        ex_mem_we = 1'b0;
        ex_mul_signed = rand_bits(1) != 0;
        v = rand_bits(3);
        ex_mem_type = v[2:0];
        v = rand_bits(4);
        if (kind == 5 || kind == 6) begin              // Load or store at imm
            ex_raddr_b1 = '0;
            ex_src_sel_b = 2'b10;
            op_b = ALU_ADD;
            ex_imm_b = {26'b0, v[3:0], 2'b00};
        end
        o1 = ex_src_sel_a[SRC_OP1_PC] ? ex_pc_a : arch[ex_raddr_a1];
        o2 = ex_src_sel_a[SRC_OP2_IMM] ? ex_imm_a : arch[ex_raddr_a2];
        pend_data_a = ref_result(op_a, o1, o2, 0, 1'b0);
        o1 = ex_src_sel_b[SRC_OP1_PC] ? ex_pc_b : arch[ex_raddr_b1];
        o2 = ex_src_sel_b[SRC_OP2_IMM] ? ex_imm_b : arch[ex_raddr_b2];
        pend_data_b = ref_result(op_b, o1, o2, 0, 1'b0);
        if (kind == 4) begin
            mul = (rand_bits(1) != 0) ? 2 : 1;
            ex_wb_sel = (mul == 2) ? 4'b1000 : 4'b0100;
            pend_data_b = ref_result(0, arch[ex_raddr_b1], arch[ex_raddr_b2], mul, ex_mul_signed);
            next_block = ex_rf_waddr_b;
        end else if (kind == 5) begin
            ex_wb_sel = 4'b0010;
            pend_data_b = ref_mem[v[3:0]];
            next_block = ex_rf_waddr_b;
        end else if (kind == 6) begin
            ex_mem_we = 1'b1;
            ex_rf_we_b = 1'b0;
            ref_mem[v[3:0]] = arch[ex_raddr_b2];
        end
        ex_alu_op_a = '0;
        ex_alu_op_a[op_a] = 1'b1;
        ex_alu_op_b = '0;
        ex_alu_op_b[op_b] = 1'b1;
        ex_rdata_a1 = hist2[ex_raddr_a1];
        ex_rdata_a2 = hist2[ex_raddr_a2];
        ex_rdata_b1 = hist2[ex_raddr_b1];
        ex_rdata_b2 = hist2[ex_raddr_b2];
        shift_history();
        if (ex_rf_we_a && ex_rf_waddr_a != 0) arch[ex_rf_waddr_a] = pend_data_a;
        if (ex_rf_we_b && ex_rf_waddr_b != 0) arch[ex_rf_waddr_b] = pend_data_b;
        blocked_reg = next_block;
        pend_we_a = ex_rf_we_a;
        pend_we_b = ex_rf_we_b;
        pend_addr_a = ex_rf_waddr_a;
        pend_addr_b = ex_rf_waddr_b;
        pend_seq = n;
        fast_mode = n < FAST_BUNDLES;
        pend_cyc = fast_mode ? cycle + 1 : -1;
        pend_valid = 1'b1;
    endtask

    task automatic drive_bubble();
        ex_rf_we_a = 1'b0;
        ex_rf_we_b = 1'b0;
        ex_mem_we = 1'b0;
        ex_wb_sel = '0;
        ex_alu_op_a = '0;
        ex_alu_op_b = '0;
        ex_mem_type = 3'b010;
        ex_mul_signed = 1'b0;
        ex_pc_a = '0;
        ex_imm_a = '0;
        ex_rdata_a1 = '0;
        ex_rdata_a2 = '0;
        ex_pc_b = '0;
        ex_imm_b = '0;
        ex_rdata_b1 = '0;
        ex_rdata_b2 = '0;
        ex_raddr_a1 = '0;
        ex_raddr_a2 = '0;
        ex_raddr_b1 = '0;
        ex_raddr_b2 = '0;
        ex_rf_waddr_a = '0;
        ex_rf_waddr_b = '0;
        ex_src_sel_a = '0;
        ex_src_sel_b = '0;
    endtask

    // Sampling, expected-write queueing and cache request capture
    always @(posedge clk) begin
        if (arst_n) begin
            cycle++;
            if (cycle > CYCLE_LIMIT) fail_run("Timeout: cycle limit reached without finishing");
            if (rf_we_b) compare_write(1'b1, rf_waddr_b, rf_wdata_b);
            if (rf_we_a) compare_write(1'b0, rf_waddr_a, rf_wdata_a);
            if (!stall && pend_valid) begin
                if (pend_we_b) begin
                    exp_lane_q.push_back(1'b1);
                    exp_addr_q.push_back(pend_addr_b);
                    exp_data_q.push_back(pend_data_b);
                    exp_cyc_q.push_back(pend_cyc);
                    exp_seq_q.push_back(pend_seq);
                end
                if (pend_we_a) begin
                    exp_lane_q.push_back(1'b0);
                    exp_addr_q.push_back(pend_addr_a);
                    exp_data_q.push_back(pend_data_a);
                    exp_cyc_q.push_back(pend_cyc);
                    exp_seq_q.push_back(pend_seq);
                end
                pend_valid = 1'b0;
            end
            if (mem_rvalid || mem_wvalid) begin
                check_mem_type("cache request mem_type", ex_mem_type, mem_type);
                cache_busy = 1'b1;
                cache_load = mem_rvalid;
                cache_idx = mem_addr[5:2];
                if (mem_wvalid) cache_mem[mem_addr[5:2]] = mem_wdata;
                cache_wait = fast_mode ? 0 : int'(rand_bits(2));
            end
        end
    end

    // Cache answer as a one-cycle ready pulse
    always @(negedge clk) begin
        mem_rready = 1'b0;
        mem_wready = 1'b0;
        if (cache_busy) begin
            if (cache_wait == 0) begin
                mem_rready = cache_load;
                mem_wready = !cache_load;
                mem_rdata = cache_mem[cache_idx];
                cache_busy = 1'b0;
            end else begin
                cache_wait--;
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        mem_rready = 1'b0;
        mem_wready = 1'b0;
        mem_rdata = '0;
        cache_busy = 1'b0;
        cache_load = 1'b0;
        cache_idx = '0;
        cache_wait = 0;
        pend_valid = 1'b0;
        fast_mode = 1'b0;
        blocked_reg = '0;
        cycle = 0;
        drive_bubble();
        arch[0] = '0;
        for (int i = 1; i < 32; i++) arch[i] = rand_bits(32);
        hist1 = arch;
        hist2 = arch;
        for (int i = 0; i < 16; i++) begin
            ref_mem[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);
            cache_mem[i] = ref_mem[i];
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_low("reset rf_we_a", rf_we_a);
        check_low("reset rf_we_b", rf_we_b);
        check_low("reset mem_rvalid", mem_rvalid);
        check_low("reset mem_wvalid", mem_wvalid);
        check_low("reset stall", stall);
        issued = 0;
        while (issued < NUM_BUNDLES) begin
            @(negedge clk);
            if (!pend_valid) begin                      // Previous bundle taken
                build_bundle(issued);
                issued++;
            end
        end
        while (pend_valid) @(negedge clk);
        drive_bubble();
        while (exp_lane_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/exec_backend_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_backend_assert (
    input logic clk,
    input logic arst_n,
    input logic mem_rvalid,
    input logic mem_wvalid,
    input logic mem_rready,
    input logic mem_wready,
    input logic stall,
    input logic rf_we_a,
    input logic rf_we_b
);

    logic acc_open;                                // Taken access not yet answered

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_open <= 1'b0;
        end else begin
            acc_open <= mem_rvalid | mem_wvalid | (acc_open & ~(mem_rready | mem_wready));
        end
    end

    a_one_request: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_rvalid && mem_wvalid)) else $error("read and write request together");

    // An unanswered access must stall and block new requests
    a_no_req_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (acc_open && !(mem_rready || mem_wready)) |-> (stall && !(mem_rvalid || mem_wvalid)))
        else $error("request valid or missing stall while an access waits");

    // First edge out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !(rf_we_a || rf_we_b)) else $error("write enable after reset");

endmodule

bind exec_backend exec_backend_assert u_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .mem_rvalid (mem_rvalid),
    .mem_wvalid (mem_wvalid),
    .mem_rready (mem_rready),
    .mem_wready (mem_wready),
    .stall      (stall),
    .rf_we_a    (rf_we_a),
    .rf_we_b    (rf_we_b)
);

`default_nettype wire

/* verilog/exec_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_backend import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    // Lane A from issue
    input  logic [XLEN-1:0]       ex_pc_a,
    input  logic [XLEN-1:0]       ex_rdata_a1,
    input  logic [XLEN-1:0]       ex_rdata_a2,
    input  logic [REG_ADDR_W-1:0] ex_raddr_a1,
    input  logic [REG_ADDR_W-1:0] ex_raddr_a2,
    input  logic [XLEN-1:0]       ex_imm_a,
    input  logic [SRC_SEL_W-1:0]  ex_src_sel_a,
    input  logic [ALU_OP_W-1:0]   ex_alu_op_a,
    input  logic                  ex_rf_we_a,
    input  logic [REG_ADDR_W-1:0] ex_rf_waddr_a,
    // Lane B from issue
    input  logic [XLEN-1:0]       ex_pc_b,
    input  logic [XLEN-1:0]       ex_rdata_b1,
    input  logic [XLEN-1:0]       ex_rdata_b2,
    input  logic [REG_ADDR_W-1:0] ex_raddr_b1,
    input  logic [REG_ADDR_W-1:0] ex_raddr_b2,
    input  logic [XLEN-1:0]       ex_imm_b,
    input  logic [SRC_SEL_W-1:0]  ex_src_sel_b,
    input  logic [ALU_OP_W-1:0]   ex_alu_op_b,
    input  logic                  ex_rf_we_b,
    input  logic [REG_ADDR_W-1:0] ex_rf_waddr_b,
    input  logic [WB_SEL_W-1:0]   ex_wb_sel,
    input  logic                  ex_mem_we,
    input  logic [MEM_TYPE_W-1:0] ex_mem_type,
    input  logic                  ex_mul_signed,
    // Data cache
    output logic                  mem_rvalid,
    output logic                  mem_wvalid,
    output logic [XLEN-1:0]       mem_addr,
    output logic [XLEN-1:0]       mem_wdata,
    output logic [MEM_TYPE_W-1:0] mem_type,
    input  logic                  mem_rready,
    input  logic                  mem_wready,
    input  logic [XLEN-1:0]       mem_rdata,
    output logic                  stall,
    // Register file write-back
    output logic                  rf_we_a,
    output logic                  rf_we_b,
    output logic [REG_ADDR_W-1:0] rf_waddr_a,
    output logic [REG_ADDR_W-1:0] rf_waddr_b,
    output logic [XLEN-1:0]       rf_wdata_a,
    output logic [XLEN-1:0]       rf_wdata_b
);

    logic [XLEN-1:0]       fwd_a1;
    logic [XLEN-1:0]       fwd_a2;
    logic [XLEN-1:0]       fwd_b1;
    logic [XLEN-1:0]       fwd_b2;
    logic [XLEN-1:0]       result_a;
    logic [XLEN-1:0]       result_b;
    logic [PROD_W-1:0]     product;
    logic                  mem_we_a;
    logic                  mem_we_b;
    logic [REG_ADDR_W-1:0] mem_waddr_a;
    logic [REG_ADDR_W-1:0] mem_waddr_b;
    logic [XLEN-1:0]       mem_result_a;
    logic [XLEN-1:0]       mem_result_b;
    logic                  wb_fwd_we_a;
    logic                  wb_fwd_we_b;

    // Memory access is lane B only
    assign mem_addr  = result_b;
    assign mem_wdata = fwd_b2;
    assign mem_type  = ex_mem_type;

    operand_forward u_fwd (
        .rdata_a1     (ex_rdata_a1),
        .rdata_a2     (ex_rdata_a2),
        .rdata_b1     (ex_rdata_b1),
        .rdata_b2     (ex_rdata_b2),
        .raddr_a1     (ex_raddr_a1),
        .raddr_a2     (ex_raddr_a2),
        .raddr_b1     (ex_raddr_b1),
        .raddr_b2     (ex_raddr_b2),
        .mem_we_a     (mem_we_a),
        .mem_we_b     (mem_we_b),
        .mem_waddr_a  (mem_waddr_a),
        .mem_waddr_b  (mem_waddr_b),
        .mem_result_a (mem_result_a),
        .mem_result_b (mem_result_b),
        .wb_we_a      (wb_fwd_we_a),
        .wb_we_b      (wb_fwd_we_b),
        .wb_waddr_a   (rf_waddr_a),
        .wb_waddr_b   (rf_waddr_b),
        .wb_wdata_a   (rf_wdata_a),
        .wb_wdata_b   (rf_wdata_b),
        .fwd_a1       (fwd_a1),
        .fwd_a2       (fwd_a2),
        .fwd_b1       (fwd_b1),
        .fwd_b2       (fwd_b2)
    );

    int_alu alu_a (
        .pc      (ex_pc_a),
        .op1_reg (fwd_a1),
        .op2_reg (fwd_a2),
        .imm     (ex_imm_a),
        .src_sel (ex_src_sel_a),
        .alu_op  (ex_alu_op_a),
        .result  (result_a)
    );

    int_alu alu_b (
        .pc      (ex_pc_b),
        .op1_reg (fwd_b1),
        .op2_reg (fwd_b2),
        .imm     (ex_imm_b),
        .src_sel (ex_src_sel_b),
        .alu_op  (ex_alu_op_b),
        .result  (result_b)
    );

    mul_stage u_mul (
        .clk        (clk),
        .arst_n     (arst_n),
        .hold       (stall),
        .x          (fwd_b1),
        .y          (fwd_b2),
        .mul_signed (ex_mul_signed),
        .product    (product)
    );

    stage_regs u_regs (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_rf_we_a    (ex_rf_we_a),
        .ex_rf_we_b    (ex_rf_we_b),
        .ex_rf_waddr_a (ex_rf_waddr_a),
        .ex_rf_waddr_b (ex_rf_waddr_b),
        .ex_result_a   (result_a),
        .ex_result_b   (result_b),
        .ex_wb_sel     (ex_wb_sel),
        .ex_mem_we     (ex_mem_we),
        .mem_rready    (mem_rready),
        .mem_wready    (mem_wready),
        .mem_rdata     (mem_rdata),
        .product       (product),
        .mem_rvalid    (mem_rvalid),
        .mem_wvalid    (mem_wvalid),
        .stall         (stall),
        .mem_we_a      (mem_we_a),
        .mem_we_b      (mem_we_b),
        .mem_waddr_a   (mem_waddr_a),
        .mem_waddr_b   (mem_waddr_b),
        .mem_result_a  (mem_result_a),
        .mem_result_b  (mem_result_b),
        .wb_fwd_we_a   (wb_fwd_we_a),
        .wb_fwd_we_b   (wb_fwd_we_b),
        .wb_rf_we_a    (rf_we_a),
        .wb_rf_we_b    (rf_we_b),
        .wb_rf_waddr_a (rf_waddr_a),
        .wb_rf_waddr_b (rf_waddr_b),
        .wb_rf_wdata_a (rf_wdata_a),
        .wb_rf_wdata_b (rf_wdata_b)
    );

endmodule

`default_nettype wire

/* verilog/stage_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_regs import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ex_rf_we_a,
    input  logic                  ex_rf_we_b,
    input  logic [REG_ADDR_W-1:0] ex_rf_waddr_a,
    input  logic [REG_ADDR_W-1:0] ex_rf_waddr_b,
    input  logic [XLEN-1:0]       ex_result_a,
    input  logic [XLEN-1:0]       ex_result_b,
    input  logic [WB_SEL_W-1:0]   ex_wb_sel,
    input  logic                  ex_mem_we,
    input  logic                  mem_rready,
    input  logic                  mem_wready,
    input  logic [XLEN-1:0]       mem_rdata,
    input  logic [PROD_W-1:0]     product,
    output logic                  mem_rvalid,
    output logic                  mem_wvalid,
    output logic                  stall,
    output logic                  mem_we_a,
    output logic                  mem_we_b,
    output logic [REG_ADDR_W-1:0] mem_waddr_a,
    output logic [REG_ADDR_W-1:0] mem_waddr_b,
    output logic [XLEN-1:0]       mem_result_a,
    output logic [XLEN-1:0]       mem_result_b,
    output logic                  wb_fwd_we_a,    // Stored enable, not gated
    output logic                  wb_fwd_we_b,
    output logic                  wb_rf_we_a,
    output logic                  wb_rf_we_b,
    output logic [REG_ADDR_W-1:0] wb_rf_waddr_a,
    output logic [REG_ADDR_W-1:0] wb_rf_waddr_b,
    output logic [XLEN-1:0]       wb_rf_wdata_a,
    output logic [XLEN-1:0]       wb_rf_wdata_b
);

    logic                mem_acc;                 // MEM bundle waits on the cache
    logic [WB_SEL_W-1:0] mem_wb_sel;
    logic [XLEN-1:0]     mem_wdata_b;
    logic                fresh;                   // WB loaded on the last edge

    assign stall      = mem_acc & ~(mem_rready | mem_wready);
    assign mem_rvalid = ex_wb_sel[WB_LOAD] & ~stall;
    assign mem_wvalid = ex_mem_we & ~stall;

    // Lane B write data in MEM
    assign mem_wdata_b = ({XLEN{mem_wb_sel[WB_ALU]}}    & mem_result_b)
                       | ({XLEN{mem_wb_sel[WB_LOAD]}}   & mem_rdata)
                       | ({XLEN{mem_wb_sel[WB_MUL_LO]}} & product[XLEN-1:0])
                       | ({XLEN{mem_wb_sel[WB_MUL_HI]}} & product[PROD_W-1:XLEN]);

    // EX/MEM control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_we_a   <= 1'b0;
            mem_we_b   <= 1'b0;
            mem_wb_sel <= '0;
            mem_acc    <= 1'b0;
        end else if (!stall) begin
            mem_we_a   <= ex_rf_we_a;
            mem_we_b   <= ex_rf_we_b;
            mem_wb_sel <= ex_wb_sel;
            mem_acc    <= mem_rvalid | mem_wvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_waddr_a  <= ex_rf_waddr_a;
            mem_waddr_b  <= ex_rf_waddr_b;
            mem_result_a <= ex_result_a;
            mem_result_b <= ex_result_b;
        end
    end

    // MEM/WB control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_fwd_we_a <= 1'b0;
            wb_fwd_we_b <= 1'b0;
            fresh       <= 1'b0;
        end else begin
            fresh <= ~stall;
            if (!stall) begin
                wb_fwd_we_a <= mem_we_a;
                wb_fwd_we_b <= mem_we_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rf_waddr_a <= mem_waddr_a;
            wb_rf_waddr_b <= mem_waddr_b;
            wb_rf_wdata_a <= mem_result_a;
            wb_rf_wdata_b <= mem_wdata_b;
        end
    end

    // One write per instruction even when WB is held
    assign wb_rf_we_a = wb_fwd_we_a & fresh;
    assign wb_rf_we_b = wb_fwd_we_b & fresh;

endmodule

`default_nettype wire

/* verilog/mul_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_stage import exec_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              hold,          // Cache stall
    input  logic [XLEN-1:0]   x,
    input  logic [XLEN-1:0]   y,
    input  logic              mul_signed,
    output logic [PROD_W-1:0] product         // Valid in MEM
);

    localparam int HALF = XLEN / 2;

    logic signed [XLEN:0]       x33;
    logic signed [XLEN:0]       y33;
    logic signed [PROD_W-1:0]   x_ext;
    logic signed [PROD_W-1:0]   ylo_ext;
    logic signed [PROD_W-1:0]   yhi_ext;
    logic signed [PROD_W-1:0]   pp_lo;
    logic signed [PROD_W-1:0]   pp_hi;
    logic [PROD_W-1:0]          pp_lo_q;
    logic [PROD_W-1:0]          pp_hi_q;

    // Sign or zero extension to 33 bits covers both flavours
    assign x33 = {mul_signed & x[XLEN-1], x};
    assign y33 = {mul_signed & y[XLEN-1], y};

    assign x_ext   = PROD_W'(x33);
    assign ylo_ext = $signed({{(PROD_W-HALF){1'b0}}, y33[HALF-1:0]});  // Low half unsigned
    assign yhi_ext = PROD_W'($signed(y33[XLEN:HALF]));                 // High half carries sign

    // EX partial sums
    assign pp_lo = x_ext * ylo_ext;
    assign pp_hi = (x_ext * yhi_ext) <<< HALF;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pp_lo_q <= '0;
            pp_hi_q <= '0;
        end else if (!hold) begin
            pp_lo_q <= pp_lo;
            pp_hi_q <= pp_hi;
        end
    end

    // Final add in MEM
    assign product = pp_lo_q + pp_hi_q;

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu import exec_pkg::*; (
    input  logic [XLEN-1:0]      pc,
    input  logic [XLEN-1:0]      op1_reg,
    input  logic [XLEN-1:0]      op2_reg,
    input  logic [XLEN-1:0]      imm,
    input  logic [SRC_SEL_W-1:0] src_sel,
    input  logic [ALU_OP_W-1:0]  alu_op,     // One-hot, zero gives zero
    output logic [XLEN-1:0]      result
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] sra;
    logic            lt_s;
    logic            lt_u;

    assign op1   = src_sel[SRC_OP1_PC] ? pc : op1_reg;
    assign op2   = src_sel[SRC_OP2_IMM] ? imm : op2_reg;
    assign shamt = op2[4:0];                 // Low 5 bits only

    assign sum  = op1 + op2;
    assign diff = op1 - op2;
    assign sra  = $signed(op1) >>> shamt;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    // Masked OR of every unit
    assign result = ({XLEN{alu_op[ALU_ADD]}}   & sum)
                  | ({XLEN{alu_op[ALU_SUB]}}   & diff)
                  | ({XLEN{alu_op[ALU_AND]}}   & (op1 & op2))
                  | ({XLEN{alu_op[ALU_OR]}}    & (op1 | op2))
                  | ({XLEN{alu_op[ALU_XOR]}}   & (op1 ^ op2))
                  | ({XLEN{alu_op[ALU_SLL]}}   & (op1 << shamt))
                  | ({XLEN{alu_op[ALU_SRL]}}   & (op1 >> shamt))
                  | ({XLEN{alu_op[ALU_SRA]}}   & sra)
                  | ({XLEN{alu_op[ALU_SLT]}}   & {{(XLEN-1){1'b0}}, lt_s})
                  | ({XLEN{alu_op[ALU_SLTU]}}  & {{(XLEN-1){1'b0}}, lt_u})
                  | ({XLEN{alu_op[ALU_PASS2]}} & op2);

endmodule

`default_nettype wire

/* verilog/operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_forward import exec_pkg::*; (
    input  logic [XLEN-1:0]       rdata_a1,
    input  logic [XLEN-1:0]       rdata_a2,
    input  logic [XLEN-1:0]       rdata_b1,
    input  logic [XLEN-1:0]       rdata_b2,
    input  logic [REG_ADDR_W-1:0] raddr_a1,
    input  logic [REG_ADDR_W-1:0] raddr_a2,
    input  logic [REG_ADDR_W-1:0] raddr_b1,
    input  logic [REG_ADDR_W-1:0] raddr_b2,
    input  logic                  mem_we_a,
    input  logic                  mem_we_b,
    input  logic [REG_ADDR_W-1:0] mem_waddr_a,
    input  logic [REG_ADDR_W-1:0] mem_waddr_b,
    input  logic [XLEN-1:0]       mem_result_a,   // ALU results only
    input  logic [XLEN-1:0]       mem_result_b,
    input  logic                  wb_we_a,
    input  logic                  wb_we_b,
    input  logic [REG_ADDR_W-1:0] wb_waddr_a,
    input  logic [REG_ADDR_W-1:0] wb_waddr_b,
    input  logic [XLEN-1:0]       wb_wdata_a,
    input  logic [XLEN-1:0]       wb_wdata_b,
    output logic [XLEN-1:0]       fwd_a1,
    output logic [XLEN-1:0]       fwd_a2,
    output logic [XLEN-1:0]       fwd_b1,
    output logic [XLEN-1:0]       fwd_b2
);

    // Newest writer wins. Lane B is younger than lane A in a bundle
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_ADDR_W-1:0] raddr,
        input logic [XLEN-1:0]       rdata
    );
        logic [XLEN-1:0] val;
        val = rdata;
        if (raddr == '0) begin
            val = rdata;                           // r0 reads as the file gives it
        end else if (mem_we_b && (mem_waddr_b == raddr)) begin
            val = mem_result_b;
        end else if (mem_we_a && (mem_waddr_a == raddr)) begin
            val = mem_result_a;
        end else if (wb_we_b && (wb_waddr_b == raddr)) begin
            val = wb_wdata_b;
        end else if (wb_we_a && (wb_waddr_a == raddr)) begin
            val = wb_wdata_a;
        end
        return val;
    endfunction

    always_comb begin
        fwd_a1 = pick(raddr_a1, rdata_a1);
        fwd_a2 = pick(raddr_a2, rdata_a2);
        fwd_b1 = pick(raddr_b1, rdata_b1);
        fwd_b2 = pick(raddr_b2, rdata_b2);
    end

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // Datapath sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;                 // r0 is never forwarded
    localparam int PROD_W     = 64;
    localparam int MEM_TYPE_W = 3;                 // Access size, passed through to the cache

    // One-hot ALU opcode, bit positions
    localparam int ALU_OP_W   = 11;
    localparam int ALU_ADD    = 0;
    localparam int ALU_SUB    = 1;
    localparam int ALU_AND    = 2;
    localparam int ALU_OR     = 3;
    localparam int ALU_XOR    = 4;
    localparam int ALU_SLL    = 5;
    localparam int ALU_SRL    = 6;
    localparam int ALU_SRA    = 7;
    localparam int ALU_SLT    = 8;
    localparam int ALU_SLTU   = 9;
    localparam int ALU_PASS2  = 10;                // Operand 2 straight through, lui style

    // Operand source select
    localparam int SRC_SEL_W   = 2;
    localparam int SRC_OP1_PC  = 0;                // Operand 1 from PC
    localparam int SRC_OP2_IMM = 1;                // Operand 2 from immediate

    // Lane B write-back select, one-hot
    localparam int WB_SEL_W  = 4;
    localparam int WB_ALU    = 0;
    localparam int WB_LOAD   = 1;
    localparam int WB_MUL_LO = 2;
    localparam int WB_MUL_HI = 3;

endpackage

`default_nettype wire
